// ==== list.f ====
+incdir+.
tenyr_pkg.sv
insn_decode.sv
reg_file.sv
alu_exec.sv
wb_master.sv
core_seq.sv
tenyr_core.sv
tb_wb_mem.sv
tb_tenyr_core.sv

// ==== tb_tenyr_core.sv ====
`timescale 1ns/1ps
`include "tenyr_params.svh"

module tb_tenyr_core;
    import tenyr_pkg::*;

    logic    i_clk;
    logic    i_reset_n;
    wb_req_t ibus_req, dbus_req;
    wb_rsp_t ibus_rsp, dbus_rsp;
    logic    halt;
    logic    dlog_valid;
    word_t   dlog_adr, dlog_dat;

    integer  seed;
    int      value_errors, other_errors, cycles, status;
    word_t   emit_adr, ref_pc, wr_adr, wr_dat, exp_a, exp_d;
    word_t   ref_regs [0:15];
    word_t   ref_imem [0:8191];
    word_t   ref_mem  [0:8191];
    word_t   exp_adr [$];
    word_t   exp_dat [$];

    tenyr_core u_dut (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .o_ibus(ibus_req), .i_ibus(ibus_rsp),
        .o_dbus(dbus_req), .i_dbus(dbus_rsp), .o_halt(halt)
    );
    tb_wb_mem u_imem (
        .i_clk(i_clk), .i_req(ibus_req), .o_rsp(ibus_rsp),
        .o_log_valid(), .o_log_adr(), .o_log_dat()
    );
    tb_wb_mem u_dmem (
        .i_clk(i_clk), .i_req(dbus_req), .o_rsp(dbus_rsp),
        .o_log_valid(dlog_valid), .o_log_adr(dlog_adr), .o_log_dat(dlog_dat)
    );

    initial i_clk = 1'b0;
    always #10 i_clk = ~i_clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input logic [3:0] got,
                             input logic [3:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic word_t encode_insn(input logic t, input logic [1:0] dr,
                                          input reg_idx_t z, input reg_idx_t x,
                                          input reg_idx_t y, input logic [3:0] op,
                                          input logic [11:0] imm);
        return {1'b0, t, dr, z, x, y, op, imm};
    endfunction

    function reg_idx_t pick_reg();
        return 4'd1 + 4'($unsigned($random(seed)) % 12);
    endfunction

    task automatic emit(input word_t insn);
        u_imem.mem[emit_adr[12:0]] = insn;
        emit_adr = emit_adr + 1;
    endtask

    function automatic word_t ref_read(input reg_idx_t idx);
        if (idx == 4'd0)
            return '0;
        if (idx == 4'd15)
            return ref_pc + 1;    // P reads one past the instruction
        return ref_regs[idx];
    endfunction

    // Runs one ISA instruction and returns 0 plain, 1 data write, 2 halt
    function automatic int ref_step(output word_t w_adr, output word_t w_dat);
        word_t    insn, xv, yv, zv, imm, opd, addend, base, rhs, val;
        logic [3:0] op;
        reg_idx_t z;
        logic [1:0] dr;
        insn  = ref_imem[ref_pc[12:0]];
        w_adr = '0;
        w_dat = '0;
        if (insn[31])
            return 2;
        dr  = insn[29:28];
        z   = insn[27:24];
        op  = insn[15:12];
        imm = {{20{insn[11]}}, insn[11:0]};
        xv  = ref_read(insn[23:20]);
        yv  = ref_read(insn[19:16]);
        zv  = ref_read(z);
        opd    = insn[30] ? imm : yv;
        addend = insn[30] ? yv : imm;
        case (op)
            op_or:   base = xv | opd;
            op_and:  base = xv & opd;
            op_add:  base = xv + opd;
            op_mul:  base = xv * opd;
            op_shl:  base = xv << opd;
            op_clt:  base = ($signed(xv) < $signed(opd)) ? -1 : 0;
            op_ceq:  base = (xv == opd) ? -1 : 0;
            op_cgt:  base = ($signed(xv) > $signed(opd)) ? -1 : 0;
            op_andn: base = xv & ~opd;
            op_xor:  base = xv ^ opd;
            op_sub:  base = xv - opd;
            op_xorn: base = ~(xv ^ opd);
            op_shr:  base = $unsigned(xv) >> $unsigned(opd);
            op_cne:  base = (xv != opd) ? -1 : 0;
            default: base = '0;
        endcase
        rhs = (op == 4'd4 || op == 4'd15) ? 0 : base + addend;
        val = dr[0] ? ref_mem[rhs[12:0]] : rhs;
        if (dr[1]) begin
            w_adr = dr[0] ? rhs : zv;
            w_dat = dr[0] ? zv : rhs;
            ref_mem[w_adr[12:0]] = w_dat;
            ref_pc = ref_pc + 1;
            return 1;
        end
        if (z == 4'd15) begin
            ref_pc = val;
        end else begin
            if (z != 4'd0)
                ref_regs[z] = val;
            ref_pc = ref_pc + 1;
        end
        return 0;
    endfunction

    task automatic build_program();
        emit_adr = `TENYR_RESET_VECTOR;
        for (int i = 1; i <= 12; i++) begin     // Random operands through loads
            u_dmem.mem[13'h100 + i] = (i == 11) ? ($random(seed) & 31) : $random(seed);
            emit(encode_insn(1'b0, 2'b01, reg_idx_t'(i), 4'd0, 4'd0, op_or, 12'h100 + i));
        end
        emit(encode_insn(1'b0, 2'b00, 4'd13, 4'd0, 4'd0, op_or, 12'h200));
        for (int op = 0; op < 16; op++) begin
            if (op == 4 || op == 15)
                continue;
            for (int t = 0; t < 2; t++)
                emit(encode_insn(t[0], 2'b10, 4'd13, pick_reg(), pick_reg(), op[3:0],
                                 $random(seed)));
        end
        u_dmem.mem[13'h110] = $random(seed);
        emit(encode_insn(1'b0, 2'b01, 4'd5, 4'd0, 4'd0, op_or, 12'h110));
        emit(encode_insn(1'b0, 2'b10, 4'd13, 4'd5, 4'd0, op_or, 12'h000));
        emit(encode_insn(1'b0, 2'b11, 4'd5, 4'd0, 4'd0, op_or, 12'h300));
        // Register 0 ignores a plain write and a load
        emit(encode_insn(1'b0, 2'b00, 4'd0, 4'd1, 4'd0, op_or, 12'h123));
        emit(encode_insn(1'b0, 2'b11, 4'd0, 4'd0, 4'd0, op_or, 12'h301));
        emit(encode_insn(1'b0, 2'b01, 4'd0, 4'd0, 4'd0, op_or, 12'h110));
        emit(encode_insn(1'b0, 2'b10, 4'd13, 4'd0, 4'd0, op_add, 12'h000));
        // Relative jump over two stores, then a jump through r14
        emit(encode_insn(1'b0, 2'b00, 4'd15, 4'd15, 4'd0, op_add, 12'd2));
        emit(encode_insn(1'b0, 2'b10, 4'd13, 4'd0, 4'd0, op_or, 12'h7ff));
        emit(encode_insn(1'b0, 2'b10, 4'd13, 4'd0, 4'd0, op_or, 12'h7fe));
        emit(encode_insn(1'b0, 2'b10, 4'd13, 4'd15, 4'd0, op_or, 12'h000));
        emit(encode_insn(1'b0, 2'b00, 4'd14, 4'd15, 4'd0, op_add, 12'd3));
        emit(encode_insn(1'b0, 2'b00, 4'd15, 4'd14, 4'd0, op_or, 12'h000));
        emit(encode_insn(1'b0, 2'b10, 4'd13, 4'd0, 4'd0, op_or, 12'h7fd));
        emit(encode_insn(1'b0, 2'b10, 4'd13, 4'd0, 4'd0, op_or, 12'h7fc));
        emit(encode_insn(1'b0, 2'b10, 4'd13, 4'd15, 4'd14, op_add, 12'h000));
        emit(`TENYR_ILLEGAL_INSN);
    endtask

    // Compares every logged data write with the next expected one
    always @(posedge i_clk) begin
        if (dlog_valid) begin
            if (exp_adr.size() == 0) begin
                other_errors++;
                $display("ERROR t=%0t data write to %h the program does not make",
                         $time, dlog_adr);
            end else begin
                exp_a = exp_adr.pop_front();
                exp_d = exp_dat.pop_front();
                check_word("o_dbus.adr", dlog_adr, exp_a);
                check_word("o_dbus.dat", dlog_dat, exp_d);
            end
        end
        if (ibus_req.cyc && ibus_req.we) begin
            other_errors++;
            $display("ERROR t=%0t fetch bus started a write cycle", $time);
        end
        if (ibus_req.stb)
            check_sel("o_ibus.sel", ibus_req.sel, 4'hf);
        if (dbus_req.stb)
            check_sel("o_dbus.sel", dbus_req.sel, 4'hf);   // Whole words
    end

    initial begin
        i_reset_n    = 1'b1;
        seed         = 32'h1e0b;
        value_errors = 0;
        other_errors = 0;
        @(negedge i_clk);
        build_program();
        for (int i = 0; i < 8192; i++) begin
            ref_imem[i] = u_imem.mem[i];
            ref_mem[i]  = u_dmem.mem[i];
        end
        for (int i = 0; i < 16; i++)
            ref_regs[i] = '0;
        ref_pc = `TENYR_RESET_VECTOR;
        status = 0;
        for (int n = 0; n < 1000 && status != 2; n++) begin
            status = ref_step(wr_adr, wr_dat);
            if (status == 1) begin
                exp_adr.push_back(wr_adr);
                exp_dat.push_back(wr_dat);
            end
        end
        repeat (9) @(negedge i_clk);
        check_bit("o_halt", halt, 1'b0);
        check_bit("o_ibus.cyc", ibus_req.cyc, 1'b0);
        check_bit("o_dbus.cyc", dbus_req.cyc, 1'b0);
        i_reset_n = 1'b0;
        cycles = 0;
        while (!ibus_req.stb && cycles < 20) begin
            @(negedge i_clk);
            cycles++;
        end
        if (ibus_req.stb)
            check_word("o_ibus.adr", ibus_req.adr, `TENYR_RESET_VECTOR);
        else begin
            other_errors++;
            $display("ERROR no fetch cycle started after reset");
        end
        cycles = 0;
        while (!halt && cycles < 20000) begin
            @(negedge i_clk);
            cycles++;
        end
        if (halt) begin
            for (int n = 0; n < 100; n++) begin   // Core must stay quiet and halted
                @(negedge i_clk);
                check_bit("o_halt", halt, 1'b1);
                if (ibus_req.cyc || dbus_req.cyc) begin
                    other_errors++;
                    $display("ERROR t=%0t bus cycle after halt", $time);
                end
            end
            if (exp_adr.size() != 0) begin
                other_errors++;
                $display("ERROR %0d expected data writes never happened", exp_adr.size());
            end
        end else begin
            other_errors++;
            $display("ERROR core did not halt within %0d cycles", cycles);
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== tb_wb_mem.sv ====
`timescale 1ns/1ps

module tb_wb_mem #(
    parameter int seed_init = 32'h1e0b
) (
    input  logic               i_clk,
    input  tenyr_pkg::wb_req_t i_req,
    output tenyr_pkg::wb_rsp_t o_rsp,
    output logic               o_log_valid,   // One cycle per acked write
    output tenyr_pkg::word_t   o_log_adr,
    output tenyr_pkg::word_t   o_log_dat
);
    import tenyr_pkg::*;

    word_t  mem [0:8191];   // Indexed by the low 13 address bits
    integer seed;
    int     wait_left;
    logic   pending;        // Request seen, wait states drawn

    initial begin
        seed        = seed_init;
        pending     = 1'b0;
        wait_left   = 0;
        o_rsp       = '0;
        o_log_valid = 1'b0;
        o_log_adr   = '0;
        o_log_dat   = '0;
        for (int i = 0; i < 8192; i++)
            mem[i] = i * 32'h9e37_79b1 + 32'h0bad_0000;
    end

    // Slave answers on the falling edge, master samples on the rising one
    always @(negedge i_clk) begin
        o_rsp.ack   <= 1'b0;
        o_log_valid <= 1'b0;
        if (i_req.cyc && i_req.stb && !o_rsp.ack) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;   // 0 to 3 wait states
            end
            if (wait_left == 0) begin
                pending    = 1'b0;
                o_rsp.ack <= 1'b1;
                o_rsp.dat <= mem[i_req.adr[12:0]];
                if (i_req.we) begin
                    mem[i_req.adr[12:0]] <= i_req.dat;
                    o_log_valid <= 1'b1;
                    o_log_adr   <= i_req.adr;
                    o_log_dat   <= i_req.dat;
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

endmodule

// ==== tenyr_core.sv ====
`timescale 1ns/1ps

module tenyr_core (
    input  logic               i_clk,
    input  logic               i_reset_n,
    output tenyr_pkg::wb_req_t o_ibus,
    input  tenyr_pkg::wb_rsp_t i_ibus,
    output tenyr_pkg::wb_req_t o_dbus,
    input  tenyr_pkg::wb_rsp_t i_dbus,
    output logic               o_halt
);
    import tenyr_pkg::*;

    decoded_t dec;
    word_t    insn, pc;
    word_t    x_val, y_val, z_val, rhs;
    logic     exec_en;
    logic     fetch_start, fetch_done;
    word_t    fetch_data;
    logic     mem_start, mem_we, mem_done;
    word_t    mem_addr, mem_wdata, mem_rdata;
    logic     reg_we;
    reg_idx_t reg_idx;
    word_t    reg_data;

    core_seq u_seq (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_dec(dec), .i_z(z_val), .i_rhs(rhs),
        .o_insn(insn), .o_pc(pc), .o_exec_en(exec_en),
        .o_fetch_start(fetch_start), .i_fetch_done(fetch_done), .i_fetch_data(fetch_data),
        .o_mem_start(mem_start), .o_mem_we(mem_we), .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata), .i_mem_done(mem_done), .i_mem_rdata(mem_rdata),
        .o_reg_we(reg_we), .o_reg_idx(reg_idx), .o_reg_data(reg_data), .o_halt(o_halt)
    );

    insn_decode u_dec (.i_insn(insn), .o_dec(dec));

    reg_file u_regs (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_x_idx(dec.x), .i_y_idx(dec.y), .i_z_idx(dec.z), .i_pc(pc),
        .o_x(x_val), .o_y(y_val), .o_z(z_val),
        .i_we(reg_we), .i_wr_idx(reg_idx), .i_wr_data(reg_data)
    );

    alu_exec u_alu (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_en(exec_en), .i_dec(dec),
        .i_x(x_val), .i_y(y_val), .o_rhs(rhs)
    );

    // Fetch bus is read only
    wb_master u_ibus (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_start(fetch_start), .i_we(1'b0),
        .i_addr(pc), .i_wdata('0), .o_done(fetch_done), .o_rdata(fetch_data),
        .o_wb(o_ibus), .i_wb(i_ibus)
    );

    wb_master u_dbus (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_start(mem_start), .i_we(mem_we),
        .i_addr(mem_addr), .i_wdata(mem_wdata), .o_done(mem_done), .o_rdata(mem_rdata),
        .o_wb(o_dbus), .i_wb(i_dbus)
    );

endmodule

// ==== core_seq.sv ====
`timescale 1ns/1ps
`include "tenyr_params.svh"

module core_seq (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  tenyr_pkg::decoded_t i_dec,
    input  tenyr_pkg::word_t    i_z,
    input  tenyr_pkg::word_t    i_rhs,
    output tenyr_pkg::word_t    o_insn,
    output tenyr_pkg::word_t    o_pc,
    output logic                o_exec_en,
    output logic                o_fetch_start,
    input  logic                i_fetch_done,
    input  tenyr_pkg::word_t    i_fetch_data,
    output logic                o_mem_start,
    output logic                o_mem_we,
    output tenyr_pkg::word_t    o_mem_addr,
    output tenyr_pkg::word_t    o_mem_wdata,
    input  logic                i_mem_done,
    input  tenyr_pkg::word_t    i_mem_rdata,
    output logic                o_reg_we,
    output tenyr_pkg::reg_idx_t o_reg_idx,
    output tenyr_pkg::word_t    o_reg_data,
    output logic                o_halt
);
    import tenyr_pkg::*;

    typedef enum logic [2:0] {st_fetch, st_exec, st_mem, st_write, st_halt} state_t;

    localparam reg_idx_t pc_idx = reg_idx_t'(`TENYR_NUM_REGS - 1);

    state_t state;
    logic   issued;     // Bus transfer of the current state already started
    logic   mem_op;
    logic   jump;
    word_t  wb_val;

    assign mem_op = i_dec.deref.z_mem | i_dec.deref.rhs_mem;
    assign jump   = !i_dec.deref.z_mem && (i_dec.z == pc_idx);
    assign wb_val = i_dec.deref.rhs_mem ? i_mem_rdata : i_rhs;  // Load or plain rhs

    assign o_fetch_start = (state == st_fetch) && !issued;
    assign o_mem_start   = (state == st_mem) && !issued;
    assign o_exec_en     = (state == st_exec) && !i_dec.illegal;

    // 01 load mem[rhs], 10 mem[Z] <- rhs, 11 mem[rhs] <- Z
    assign o_mem_we    = i_dec.deref.z_mem;
    assign o_mem_addr  = i_dec.deref.rhs_mem ? i_rhs : i_z;
    assign o_mem_wdata = i_dec.deref.rhs_mem ? i_z : i_rhs;

    assign o_reg_we   = (state == st_write) && !i_dec.deref.z_mem;
    assign o_reg_idx  = i_dec.z;
    assign o_reg_data = wb_val;

    always_ff @(posedge i_clk) begin
        if (i_reset_n) begin
            state  <= st_fetch;
            issued <= 1'b0;
            o_pc   <= `TENYR_RESET_VECTOR;
            o_halt <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (o_fetch_start)
                        issued <= 1'b1;
                    if (i_fetch_done) begin
                        issued <= 1'b0;
                        state  <= st_exec;
                    end
                end
                st_exec: begin
                    if (i_dec.illegal) begin
                        state  <= st_halt;
                        o_halt <= 1'b1;
                    end else begin
                        state <= mem_op ? st_mem : st_write;
                    end
                end
                st_mem: begin
                    if (o_mem_start)
                        issued <= 1'b1;
                    if (i_mem_done) begin
                        issued <= 1'b0;
                        state  <= st_write;
                    end
                end
                st_write: begin
                    o_pc  <= jump ? wb_val : o_pc + 1;
                    state <= st_fetch;
                end
                default: state <= st_halt;  // Stays here until reset
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge i_clk) begin
        if (state == st_fetch && i_fetch_done) begin
            o_insn <= i_fetch_data;
        end
    end

endmodule

// ==== wb_master.sv ====
`timescale 1ns/1ps

module wb_master (
    input  logic               i_clk,
    input  logic               i_reset_n,
    input  logic               i_start,
    input  logic               i_we,
    input  tenyr_pkg::word_t   i_addr,
    input  tenyr_pkg::word_t   i_wdata,
    output logic               o_done,
    output tenyr_pkg::word_t   o_rdata,
    output tenyr_pkg::wb_req_t o_wb,
    input  tenyr_pkg::wb_rsp_t i_wb
);
    import tenyr_pkg::*;

    logic  active;      // Cycle in progress, waiting for ack
    logic  we_q;
    word_t adr_q;
    word_t dat_q;

    always_ff @(posedge i_clk) begin
        if (i_reset_n) begin
            active <= 1'b0;
            we_q   <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!active) begin
                if (i_start) begin
                    active <= 1'b1;
                    we_q   <= i_we;
                end
            end else if (i_wb.ack) begin
                active <= 1'b0;
                we_q   <= 1'b0;
                o_done <= 1'b1;   // One cycle after ack
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!active && i_start) begin
            adr_q <= i_addr;
            dat_q <= i_wdata;
        end
        if (active && i_wb.ack) begin
            o_rdata <= i_wb.dat;  // Held until the next ack
        end
    end

    // Whole words only
    assign o_wb = '{cyc: active, stb: active, we: we_q, adr: adr_q, dat: dat_q, sel: 4'hf};

    a_stb_cyc: assert property (
        @(posedge i_clk) disable iff (i_reset_n)
        o_wb.stb |-> o_wb.cyc
    );

    // Classic cycle holds the request until the slave acks
    a_req_stable: assert property (
        @(posedge i_clk) disable iff (i_reset_n)
        (o_wb.stb && !i_wb.ack) |=> ($stable(o_wb.adr) && $stable(o_wb.dat)
                                     && $stable(o_wb.we) && o_wb.stb)
    );

    a_start_idle: assert property (
        @(posedge i_clk) disable iff (i_reset_n)
        i_start |-> !active
    );

endmodule

// ==== alu_exec.sv ====
`timescale 1ns/1ps

module alu_exec (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_en,
    input  tenyr_pkg::decoded_t i_dec,
    input  tenyr_pkg::word_t    i_x,
    input  tenyr_pkg::word_t    i_y,
    output tenyr_pkg::word_t    o_rhs
);
    import tenyr_pkg::*;

    word_t opd;         // O, second operand of the operation
    word_t addend;      // A, added after the operation
    word_t base;
    logic  reserved;

    // Type 1 swaps the roles of Y and the immediate
    assign opd    = i_dec.type_bit ? i_dec.imm : i_y;
    assign addend = i_dec.type_bit ? i_y : i_dec.imm;

    always_comb begin
        base     = '0;
        reserved = 1'b0;
        case (i_dec.op)
            op_or:   base = i_x | opd;
            op_and:  base = i_x & opd;
            op_add:  base = i_x + opd;
            op_mul:  base = i_x * opd;       // Low word of the product
            op_shl:  base = i_x << opd;
            op_clt:  base = {32{i_x < opd}};
            op_ceq:  base = {32{i_x == opd}};
            op_cgt:  base = {32{i_x > opd}};
            op_andn: base = i_x & ~opd;
            op_xor:  base = i_x ^ opd;
            op_sub:  base = i_x - opd;
            op_xorn: base = i_x ^ ~opd;
            op_shr:  base = i_x >> opd;      // Zero fill
            op_cne:  base = {32{i_x != opd}};
            default: reserved = 1'b1;        // Opcodes 4 and 15
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_rhs <= reserved ? '0 : base + addend;
        end
    end

    // Decode must be settled by the time the sequencer enables execute
    a_op_known: assert property (
        @(posedge i_clk) disable iff (i_reset_n)
        i_en |-> !$isunknown(i_dec.op)
    );

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps
`include "tenyr_params.svh"

module reg_file (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  tenyr_pkg::reg_idx_t i_x_idx,
    input  tenyr_pkg::reg_idx_t i_y_idx,
    input  tenyr_pkg::reg_idx_t i_z_idx,
    input  tenyr_pkg::word_t    i_pc,
    output tenyr_pkg::word_t    o_x,
    output tenyr_pkg::word_t    o_y,
    output tenyr_pkg::word_t    o_z,
    input  logic                i_we,
    input  tenyr_pkg::reg_idx_t i_wr_idx,
    input  tenyr_pkg::word_t    i_wr_data
);
    import tenyr_pkg::*;

    localparam reg_idx_t pc_idx = reg_idx_t'(`TENYR_NUM_REGS - 1);

    // Slot 0 is never written or read, P lives in the sequencer
    word_t store [0:`TENYR_NUM_REGS-2];

    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0)
            val = '0;
        else if (idx == pc_idx)
            val = i_pc + 1;     // P reads one past the current insn
        else
            val = store[idx];
        return val;
    endfunction

    always_comb begin
        o_x = read_port(i_x_idx);
        o_y = read_port(i_y_idx);
        o_z = read_port(i_z_idx);
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n && i_we && i_wr_idx != '0 && i_wr_idx != pc_idx) begin
            store[i_wr_idx] <= i_wr_data;
        end
    end

    // A write with an unknown index would corrupt an arbitrary register
    a_we_idx_known: assert property (
        @(posedge i_clk) disable iff (i_reset_n)
        i_we |-> !$isunknown(i_wr_idx)
    );

endmodule

// ==== insn_decode.sv ====
`timescale 1ns/1ps
`include "tenyr_params.svh"

module insn_decode (
    input  tenyr_pkg::word_t    i_insn,
    output tenyr_pkg::decoded_t o_dec
);
    import tenyr_pkg::*;

    insn_fields_t fields;
    logic         all_ones;

    assign fields   = i_insn;
    assign all_ones = (i_insn == `TENYR_ILLEGAL_INSN);

    always_comb begin
        o_dec.op       = fields.op;
        o_dec.deref    = fields.deref;
        o_dec.z        = fields.z;
        o_dec.x        = fields.x;
        o_dec.y        = fields.y;
        o_dec.type_bit = fields.type_bit;
        o_dec.imm      = {{20{fields.imm[11]}}, fields.imm};

        // Class 1 has no defined encodings apart from the halt word,
        // so every class 1 word stops the core
        o_dec.illegal  = all_ones | fields.iclass;
    end

endmodule

// ==== tenyr_pkg.sv ====
package tenyr_pkg;

    typedef logic signed [31:0] word_t;   // Data or word address
    typedef logic [3:0] reg_idx_t;

    // Gaps at 4 and 15 are the reserved opcodes
    typedef enum logic [3:0] {
        op_or   = 4'd0,
        op_and  = 4'd1,
        op_add  = 4'd2,
        op_mul  = 4'd3,
        op_shl  = 4'd5,
        op_clt  = 4'd6,   // Signed compares give all ones when true
        op_ceq  = 4'd7,
        op_cgt  = 4'd8,
        op_andn = 4'd9,
        op_xor  = 4'd10,
        op_sub  = 4'd11,
        op_xorn = 4'd12,
        op_shr  = 4'd13,  // Logical
        op_cne  = 4'd14
    } alu_op_t;

    typedef struct packed {
        logic z_mem;      // Z is a memory location
        logic rhs_mem;    // Right-hand side is an address
    } deref_t;

    // Raw instruction layout, msb first
    typedef struct packed {
        logic      iclass;
        logic      type_bit;
        deref_t    deref;
        reg_idx_t  z;
        reg_idx_t  x;
        reg_idx_t  y;
        alu_op_t   op;
        logic [11:0] imm;
    } insn_fields_t;

    typedef struct packed {
        alu_op_t  op;
        deref_t   deref;
        reg_idx_t z;
        reg_idx_t x;
        reg_idx_t y;
        word_t    imm;        // Already sign-extended
        logic     type_bit;
        logic     illegal;
    } decoded_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        word_t      dat;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

endpackage

// ==== tenyr_params.svh ====
`ifndef TENYR_PARAMS_SVH
`define TENYR_PARAMS_SVH

// Word address of the first fetch after reset
`define TENYR_RESET_VECTOR 32'h0000_1000

// Architectural register count, top index is P
`define TENYR_NUM_REGS 16

// All-ones word, stops the core for good
`define TENYR_ILLEGAL_INSN 32'hffff_ffff

`endif
